//--- sim/exec_trace.txt
# unit alu br div mem we wsel rd pc op_a op_b st_data flags(lt,ltu,eq) mem_word
# exp_result exp_taken exp_target exp_mask exp_addr  (all hex, mem_word is wdata for stores)
1 0 0 0 0 1 0 01 00002 00001234 00000fff 00000000 0 00000000 00002233 0 00000 0 00000000
1 1 0 0 0 1 0 02 00004 00000005 00000007 00000000 0 00000000 fffffffe 0 00000 0 00000000
1 2 0 0 0 1 0 03 00006 f0f0ff00 0ff00ff0 00000000 0 00000000 00f00f00 0 00000 0 00000000
1 3 0 0 0 1 0 04 00008 f0f0ff00 0ff00ff0 00000000 0 00000000 fff0fff0 0 00000 0 00000000
1 4 0 0 0 1 0 05 0000a f0f0ff00 0ff00ff0 00000000 0 00000000 ff00f0f0 0 00000 0 00000000
1 5 0 0 0 1 0 06 0000c 00000001 0000001f 00000000 0 00000000 80000000 0 00000 0 00000000
1 6 0 0 0 1 0 07 0000e 80000000 00000004 00000000 0 00000000 08000000 0 00000 0 00000000
1 7 0 0 0 1 0 08 00010 80000000 00000024 00000000 0 00000000 f8000000 0 00000 0 00000000
1 8 0 0 0 1 0 09 00012 ffffffff 00000001 00000000 0 00000000 00000001 0 00000 0 00000000
1 9 0 0 0 1 0 0a 00014 ffffffff 00000001 00000000 0 00000000 00000000 0 00000 0 00000000
1 a 0 0 0 1 0 0b 00016 00000000 12345000 00000000 0 00000000 12345000 0 00000 0 00000000
1 0 7 0 0 1 1 01 00104 00000200 00000040 00000000 0 00000000 00000240 1 00120 0 00000000
1 0 8 0 0 1 1 05 00106 00010001 00000003 00000000 0 00000000 00010004 1 08002 0 00000000
0 0 1 0 0 0 0 00 00108 00000100 00000020 00000000 1 00000000 00000000 1 00090 0 00000000
0 0 2 0 0 0 0 00 0010a 00000100 fffffff0 00000000 1 00000000 00000000 0 00078 0 00000000
0 0 3 0 0 0 0 00 0010c 00001000 00000010 00000000 4 00000000 00000000 1 00808 0 00000000
0 0 4 0 0 0 0 00 0010e 00001000 00000010 00000000 4 00000000 00000000 0 00808 0 00000000
0 0 5 0 0 0 0 00 00110 0003fffe 00000002 00000000 2 00000000 00000000 1 20000 0 00000000
0 0 6 0 0 0 0 00 00112 00000000 00000008 00000000 0 00000000 00000000 1 00004 0 00000000
0 0 0 0 0 0 0 00 00114 00000000 00000000 00000000 7 00000000 00000000 0 00000 0 00000000
2 0 0 0 0 1 0 0c 00020 fffffff9 00000002 00000000 0 00000000 fffffffd 0 00000 0 00000000
2 0 0 2 0 1 0 0d 00022 fffffff9 00000002 00000000 0 00000000 ffffffff 0 00000 0 00000000
2 0 0 1 0 1 0 0e 00024 00000064 00000007 00000000 0 00000000 0000000e 0 00000 0 00000000
2 0 0 3 0 1 0 0f 00026 00000064 00000007 00000000 0 00000000 00000002 0 00000 0 00000000
2 0 0 0 0 1 0 10 00028 00000005 00000000 00000000 0 00000000 ffffffff 0 00000 0 00000000
2 0 0 2 0 1 0 11 0002a 00000005 00000000 00000000 0 00000000 00000005 0 00000 0 00000000
2 0 0 1 0 1 0 12 0002c 12345678 00000000 00000000 0 00000000 ffffffff 0 00000 0 00000000
2 0 0 0 0 1 0 13 0002e 80000000 ffffffff 00000000 0 00000000 80000000 0 00000 0 00000000
2 0 0 2 0 1 0 14 00030 80000000 ffffffff 00000000 0 00000000 00000000 0 00000 0 00000000
3 0 0 0 a 0 0 00 00032 00001000 00000004 deadbeef 0 deadbeef 00000000 0 00000 f 00001004
3 0 0 0 2 0 0 00 00034 00001000 00000003 000000a5 0 a5a5a5a5 00000000 0 00000 8 00001003
3 0 0 0 6 0 0 00 00036 00001000 00000002 0000beef 0 beefbeef 00000000 0 00000 c 00001002
3 0 0 0 8 1 0 15 00038 00002000 00000008 00000000 0 cafef00d cafef00d 0 00000 f 00002008
3 0 0 0 0 1 0 16 0003a 00002000 00000001 00000000 0 11228344 ffffff83 0 00000 2 00002001
3 0 0 0 1 1 0 17 0003c 00002000 00000003 00000000 0 80112233 00000080 0 00000 8 00002003
3 0 0 0 4 1 0 18 0003e 00002000 00000002 00000000 0 9abc1234 ffff9abc 0 00000 c 00002002
3 0 0 0 5 1 0 19 00040 00002000 00000000 00000000 0 5555f00f 0000f00f 0 00000 3 00002000
1 0 0 0 0 1 0 1a 00042 00000001 00000001 00000000 0 00000000 00000002 0 00000 0 00000000

//--- exec_stage.f
+incdir+include
hdl/mem_pkg.sv
hdl/uop_pkg.sv
hdl/alu_unit.sv
hdl/div_unit.sv
hdl/lsu_unit.sv
hdl/exec_ctrl.sv
hdl/exec_stage.sv
sim/tb_exec_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f exec_stage.f --top-module tb_exec_stage -o tb_exec_stage
./obj_dir/tb_exec_stage 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

//--- sim/tb_exec_stage.sv
// Trace-driven testbench for the execute stage with memory model and random stalls

`include "exec_defines.svh"

module tb_exec_stage import uop_pkg::*, mem_pkg::*; ();

    localparam int          TIMEOUT   = 200;
    localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

    logic                  clk_i;
    logic                  rst_i;
    logic                  stall_i;
    exec_uop_t             uop_i;
    mem_rsp_t              mem_rsp_i;
    logic                  ready_o;
    logic                  br_taken_o;
    logic [`EXEC_PC_W:1]   br_target_o;
    logic [`EXEC_XLEN-1:0] fwd_o;
    exec_wb_t              wb_o;
    mem_req_t              mem_req_o;
    logic                  mem_sel_o;

    logic [31:0]           lfsr_state;
    int                    burst_left;
    logic                  stall_prev;    // stall_i seen by the last edge
    exec_wb_t              wb_last;

    exec_stage uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stall_i     (stall_i),
        .uop_i       (uop_i),
        .mem_rsp_i   (mem_rsp_i),
        .ready_o     (ready_o),
        .br_taken_o  (br_taken_o),
        .br_target_o (br_target_o),
        .fwd_o       (fwd_o),
        .wb_o        (wb_o),
        .mem_req_o   (mem_req_o),
        .mem_sel_o   (mem_sel_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // Right-shifting Galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        int         i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val        = {val[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    // Bursts of one to four stalled cycles
    function automatic logic next_stall();
        if (burst_left > 0) begin
            burst_left--;
            return 1'b1;
        end
        if (rand_bits(3) == 0) begin
            burst_left = int'(rand_bits(2));
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "%s", what);
    endtask

    // Holds one micro-op until consumed, then checks the writeback register
    task automatic run_op(input exec_uop_t op, input logic [31:0] mem_word,
                          input logic [31:0] exp_res, input logic exp_taken,
                          input logic [`EXEC_PC_W-1:0] exp_target,
                          input logic [3:0] exp_mask, input logic [31:0] exp_addr);
        int cyc;
        int first_ready;
        int accesses;
        bit done;
        cyc         = 0;
        first_ready = -1;
        accesses    = 0;
        done        = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            uop_i           = op;
            stall_i         = next_stall();
            mem_rsp_i.rdata = mem_word;
            mem_rsp_i.stall = mem_sel_o && (rand_bits(1) != 0);
            #2;
            if (stall_prev) begin
                check_eq("wb_o held in stall", 64'(wb_o), 64'(wb_last));
            end
            if (op.unit == UNIT_LSU && cyc > 0) begin   // Request captured at launch
                check_eq("mem_req_o.addr", mem_req_o.addr, exp_addr);
                check_eq("mem_req_o.mask", mem_req_o.mask, exp_mask);
                check_eq("mem_req_o.write", mem_req_o.write, op.mem_op.store);
                if (op.mem_op.store) begin
                    check_eq("mem_req_o.wdata", mem_req_o.wdata, mem_word);
                end
            end
            if (mem_sel_o && !mem_rsp_i.stall) begin
                accesses++;     // Next edge completes a memory access
            end
            if (ready_o && first_ready < 0) begin
                first_ready = cyc;
            end
            if (ready_o && !stall_i) begin
                if (op.we) begin
                    check_eq("fwd_o", fwd_o, exp_res);
                end
                check_eq("br_taken_o", br_taken_o, exp_taken);
                if (op.br_op != BR_NONE) begin
                    check_eq("br_target_o", br_target_o, exp_target);
                end
                done = 1'b1;
            end
            stall_prev = stall_i;
            wb_last    = wb_o;
            cyc++;
            if (!done && cyc >= TIMEOUT) begin
                abort_run("Timeout: micro-op was never consumed by the execute stage");
            end
        end

        // Start pulse, then one cycle per quotient bit
        if (op.unit == UNIT_DIV) begin
            check_eq("ready_o delay", first_ready, `EXEC_DIV_STEPS + 1);
        end else if (op.unit != UNIT_LSU) begin
            check_eq("ready_o delay", first_ready, 0);
        end

        // Exactly one completed access for a load or store
        check_eq("mem_sel_o access count", accesses, (op.unit == UNIT_LSU) ? 1 : 0);

        @(negedge clk_i);
        uop_i     = '0;     // Bubble
        stall_i   = 1'b0;
        mem_rsp_i = '0;
        #2;
        check_eq("wb_o.we", wb_o.we, op.we);
        if (op.we) begin
            check_eq("wb_o.rd", wb_o.rd, op.rd);
            check_eq("wb_o.wb_sel", wb_o.wb_sel, op.wb_sel);
            check_eq("wb_o.pc_inc", wb_o.pc_inc, op.pc_inc);
            check_eq("wb_o.result", wb_o.result, exp_res);
        end
        stall_prev = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        int          n_ops;
        string       line;
        logic [31:0] col [19];
        exec_uop_t   op;

        rst_i      = 1'b1;
        stall_i    = 1'b0;
        uop_i      = '0;
        mem_rsp_i  = '0;
        lfsr_state = 32'd81126;
        burst_left = 0;
        stall_prev = 1'b0;
        wb_last    = '0;
        n_ops      = 0;
        line_no    = 0;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        #2;
        check_eq("ready_o", ready_o, 1'b1);
        check_eq("mem_sel_o", mem_sel_o, 1'b0);
        check_eq("wb_o.we", wb_o.we, 1'b0);

        fd = $fopen("sim/exec_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file sim/exec_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                        col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                        col[14], col[15], col[16], col[17], col[18]);
            if (n != 19) begin
                abort_run($sformatf("Trace line %0d has %0d fields, 19 needed", line_no, n));
            end
            op           = '0;
            op.unit      = unit_sel_e'(col[0][1:0]);
            op.alu_op    = alu_op_e'(col[1][3:0]);
            op.br_op     = br_op_e'(col[2][3:0]);
            op.div_op    = div_op_e'(col[3][1:0]);
            op.mem_op    = mem_op_t'(col[4][3:0]);
            op.we        = col[5][0];
            op.wb_sel    = wb_sel_e'(col[6][0]);
            op.rd        = col[7][`EXEC_RA_W-1:0];
            op.pc_inc    = col[8][`EXEC_PC_W-1:0];
            op.op_a      = col[9];
            op.op_b      = col[10];
            op.st_data   = col[11];
            op.lt_ltu_eq = col[12][2:0];
            run_op(op, col[13], col[14], col[15][0], col[16][`EXEC_PC_W-1:0],
                   col[17][3:0], col[18]);
            n_ops++;
        end
        $fclose(fd);

        if (n_ops == 0) begin
            abort_run("The trace file held no micro-ops");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- hdl/exec_stage.sv
// Execute stage top level with the ALU, divider and load/store unit around the control block

`include "exec_defines.svh"

module exec_stage import uop_pkg::*, mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  exec_uop_t             uop_i,
    input  mem_rsp_t              mem_rsp_i,
    output logic                  ready_o,
    output logic                  br_taken_o,
    output logic [`EXEC_PC_W:1]   br_target_o,
    output logic [`EXEC_XLEN-1:0] fwd_o,
    output exec_wb_t              wb_o,
    output mem_req_t              mem_req_o,
    output logic                  mem_sel_o
);

    logic [`EXEC_XLEN-1:0] alu_res;
    logic [`EXEC_XLEN-1:0] alu_sum;
    logic [`EXEC_XLEN-1:0] div_res;
    logic [`EXEC_XLEN-1:0] lsu_res;
    logic                  div_start;
    logic                  div_done;
    logic                  lsu_start;
    logic                  lsu_done;

    alu_unit u_alu (
        .op_i  (uop_i.alu_op),
        .a_i   (uop_i.op_a),
        .b_i   (uop_i.op_b),
        .res_o (alu_res),
        .sum_o (alu_sum)
    );

    div_unit u_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (uop_i.div_op),
        .dividend_i (uop_i.op_a),
        .divisor_i  (uop_i.op_b),
        .res_o      (div_res),
        .done_o     (div_done)
    );

    lsu_unit u_lsu (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (lsu_start),
        .stall_i   (stall_i),
        .op_i      (uop_i.mem_op),
        .addr_i    (alu_sum),           // Base plus offset
        .wdata_i   (uop_i.st_data),
        .mem_rsp_i (mem_rsp_i),
        .mem_req_o (mem_req_o),
        .mem_sel_o (mem_sel_o),
        .rdata_o   (lsu_res),
        .done_o    (lsu_done)
    );

    exec_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stall_i     (stall_i),
        .uop_i       (uop_i),
        .alu_res_i   (alu_res),
        .div_res_i   (div_res),
        .lsu_res_i   (lsu_res),
        .div_done_i  (div_done),
        .lsu_done_i  (lsu_done),
        .div_start_o (div_start),
        .lsu_start_o (lsu_start),
        .ready_o     (ready_o),
        .br_taken_o  (br_taken_o),
        .fwd_o       (fwd_o),
        .wb_o        (wb_o)
    );

    // pc+imm or rs1+imm in half-word units
    assign br_target_o = alu_sum[`EXEC_PC_W:1];

endmodule

//--- hdl/exec_ctrl.sv
// Execute control with unit start pulses, ready, branch resolve and writeback register

`include "exec_defines.svh"

module exec_ctrl import uop_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  exec_uop_t             uop_i,
    input  logic [`EXEC_XLEN-1:0] alu_res_i,
    input  logic [`EXEC_XLEN-1:0] div_res_i,
    input  logic [`EXEC_XLEN-1:0] lsu_res_i,
    input  logic                  div_done_i,
    input  logic                  lsu_done_i,
    output logic                  div_start_o,
    output logic                  lsu_start_o,
    output logic                  ready_o,
    output logic                  br_taken_o,
    output logic [`EXEC_XLEN-1:0] fwd_o,
    output exec_wb_t              wb_o
);

    logic                  launched_q;    // Current micro-op already started
    logic                  multi_cycle;
    logic                  launch;
    logic                  consume;
    logic                  lt;
    logic                  ltu;
    logic                  eq;
    logic [`EXEC_XLEN-1:0] next_res;

    assign multi_cycle = (uop_i.unit == UNIT_DIV) || (uop_i.unit == UNIT_LSU);
    assign launch      = multi_cycle && !launched_q;
    assign div_start_o = launch && (uop_i.unit == UNIT_DIV);
    assign lsu_start_o = launch && (uop_i.unit == UNIT_LSU);

    // Unit done levels still show the old op during the launch cycle
    assign ready_o = div_done_i & lsu_done_i & ~launch;
    assign consume = ready_o & ~stall_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            launched_q <= 1'b0;
        end else if (consume) begin
            launched_q <= 1'b0;
        end else if (launch) begin
            launched_q <= 1'b1;
        end
    end

    assign {lt, ltu, eq} = uop_i.lt_ltu_eq;

    always_comb begin
        case (uop_i.br_op)
            BR_EQ:   br_taken_o = eq;
            BR_NE:   br_taken_o = ~eq;
            BR_LT:   br_taken_o = lt;
            BR_GE:   br_taken_o = ~lt;
            BR_LTU:  br_taken_o = ltu;
            BR_GEU:  br_taken_o = ~ltu;
            BR_JAL,
            BR_JALR: br_taken_o = 1'b1;
            default: br_taken_o = 1'b0;  // Never jump on an unknown op
        endcase
    end

    always_comb begin
        case (uop_i.unit)
            UNIT_ALU: next_res = alu_res_i;
            UNIT_DIV: next_res = div_res_i;
            UNIT_LSU: next_res = lsu_res_i;
            default:  next_res = '0;
        endcase
    end

    assign fwd_o = next_res;

    // Edges that do not consume the micro-op load a bubble
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o <= '0;
        end else if (!stall_i) begin
            wb_o.we     <= uop_i.we & ready_o;
            wb_o.wb_sel <= uop_i.wb_sel;
            wb_o.rd     <= uop_i.rd;
            wb_o.pc_inc <= uop_i.pc_inc;
            wb_o.result <= next_res;
        end
    end

endmodule

//--- hdl/lsu_unit.sv
// Load/store unit with byte lanes, memory stall handling and load extension

`include "exec_defines.svh"

module lsu_unit import mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic                  stall_i,
    input  mem_op_t               op_i,
    input  logic [`EXEC_XLEN-1:0] addr_i,
    input  logic [`EXEC_XLEN-1:0] wdata_i,
    input  mem_rsp_t              mem_rsp_i,
    output mem_req_t              mem_req_o,
    output logic                  mem_sel_o,
    output logic [`EXEC_XLEN-1:0] rdata_o,
    output logic                  done_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_HOLD     // Request formed while the pipeline is stalled
    } state_e;

    state_e                state_q;
    mem_op_t               op_q;
    mem_req_t              req_q;
    logic [`EXEC_XLEN-1:0] rdata_q;

    logic [3:0]            mask;
    logic [`EXEC_XLEN-1:0] wdata_al;
    logic [`EXEC_XLEN-1:0] rd_shift;
    logic [`EXEC_XLEN-1:0] rd_ext;
    logic                  accept;

    always_comb begin
        case (op_i.size)
            MEM_BYTE: begin
                mask     = 4'b0001 << addr_i[1:0];
                wdata_al = {4{wdata_i[7:0]}};
            end
            MEM_HALF: begin
                mask     = 4'b0011 << {addr_i[1], 1'b0};
                wdata_al = {2{wdata_i[15:0]}};
            end
            default: begin
                mask     = 4'b1111;
                wdata_al = wdata_i;
            end
        endcase
    end

    assign accept   = (state_q == ST_ACCESS) && !mem_rsp_i.stall;
    assign rd_shift = mem_rsp_i.rdata >> {req_q.addr[1:0], 3'b000};

    always_comb begin
        case (op_q.size)
            MEM_BYTE: rd_ext = {{24{~op_q.uns & rd_shift[7]}}, rd_shift[7:0]};
            MEM_HALF: rd_ext = {{16{~op_q.uns & rd_shift[15]}}, rd_shift[15:0]};
            default:  rd_ext = mem_rsp_i.rdata;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= stall_i ? ST_HOLD : ST_ACCESS;
                    end
                end
                ST_HOLD: begin
                    if (!stall_i) begin
                        state_q <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (!mem_rsp_i.stall) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            op_q        <= op_i;
            req_q.addr  <= addr_i;
            req_q.wdata <= wdata_al;
            req_q.mask  <= mask;
            req_q.write <= op_i.store;
        end
        if (accept && !op_q.store) begin
            rdata_q <= rd_ext;      // Held until the next load
        end
    end

    assign mem_req_o = req_q;
    assign mem_sel_o = (state_q == ST_ACCESS);
    assign rdata_o   = rdata_q;
    assign done_o    = (state_q == ST_IDLE);

endmodule

//--- hdl/div_unit.sv
// Iterative radix-2 divider for signed and unsigned divide and remainder

`include "exec_defines.svh"

module div_unit import uop_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  div_op_e               op_i,
    input  logic [`EXEC_XLEN-1:0] dividend_i,
    input  logic [`EXEC_XLEN-1:0] divisor_i,
    output logic [`EXEC_XLEN-1:0] res_o,
    output logic                  done_o
);

    localparam int W     = `EXEC_XLEN;
    localparam int CNT_W = $clog2(`EXEC_DIV_STEPS);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [W-1:0]     rem_q;        // Partial remainder
    logic [W-1:0]     quo_q;        // Dividend shifts out as quotient shifts in
    logic [W-1:0]     dvs_q;        // Divisor magnitude
    logic             rem_sel_q;
    logic             neg_quo_q;
    logic             neg_rem_q;

    logic             is_signed;
    logic             neg_a;
    logic             neg_b;
    logic [W:0]       shifted;
    logic [W:0]       trial;

    assign is_signed = (op_i == DIV_DIV) || (op_i == DIV_REM);
    assign neg_a     = is_signed & dividend_i[W-1];
    assign neg_b     = is_signed & divisor_i[W-1];

    assign shifted = {rem_q, quo_q[W-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(`EXEC_DIV_STEPS - 1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q     <= '0;
            quo_q     <= neg_a ? -dividend_i : dividend_i;
            dvs_q     <= neg_b ? -divisor_i : divisor_i;
            rem_sel_q <= (op_i == DIV_REM) || (op_i == DIV_REMU);
            // Zero divisor keeps the all-ones quotient unsigned
            neg_quo_q <= (neg_a ^ neg_b) && (divisor_i != '0);
            neg_rem_q <= neg_a;     // Remainder takes the dividend sign
        end else if (busy_q) begin
            if (trial[W]) begin
                rem_q <= shifted[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end else begin
                rem_q <= trial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end
        end
    end

    // Overflow falls out as |min| / 1 negating back to min with remainder 0
    assign res_o = rem_sel_q ? (neg_rem_q ? -rem_q : rem_q)
                             : (neg_quo_q ? -quo_q : quo_q);

    assign done_o = ~busy_q;

endmodule

//--- hdl/alu_unit.sv
// Combinational integer ALU with a separate adder output for targets and addresses

`include "exec_defines.svh"

module alu_unit import uop_pkg::*; (
    input  alu_op_e               op_i,
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    output logic [`EXEC_XLEN-1:0] res_o,
    output logic [`EXEC_XLEN-1:0] sum_o
);

    localparam int W    = `EXEC_XLEN;
    localparam int SH_W = $clog2(`EXEC_XLEN);

    logic [W:0]      diff;      // Extra bit is the unsigned borrow
    logic [SH_W-1:0] shamt;
    logic            lt_s;
    logic            lt_u;

    assign sum_o = a_i + b_i;
    assign diff  = {1'b0, a_i} - {1'b0, b_i};
    assign shamt = b_i[SH_W-1:0];

    // Differing signs decide directly, else the difference sign does
    assign lt_s = (a_i[W-1] != b_i[W-1]) ? a_i[W-1] : diff[W-1];
    assign lt_u = diff[W];

    always_comb begin
        case (op_i)
            ALU_ADD:  res_o = sum_o;
            ALU_SUB:  res_o = diff[W-1:0];
            ALU_AND:  res_o = a_i & b_i;
            ALU_OR:   res_o = a_i | b_i;
            ALU_XOR:  res_o = a_i ^ b_i;
            ALU_SLL:  res_o = a_i << shamt;
            ALU_SRL:  res_o = a_i >> shamt;
            ALU_SRA:  res_o = $signed(a_i) >>> shamt;
            ALU_SLT:  res_o = W'(lt_s);
            ALU_SLTU: res_o = W'(lt_u);
            ALU_PASS: res_o = b_i;      // Immediate already shifted by decode
            default:  res_o = '0;
        endcase
    end

endmodule

//--- hdl/uop_pkg.sv
// Micro-operation and writeback types of the execute stage

`include "exec_defines.svh"

package uop_pkg;

    import mem_pkg::*;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_DIV  = 2'd2,
        UNIT_LSU  = 2'd3
    } unit_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_PASS = 4'd10    // lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } br_op_e;

    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } div_op_e;

    typedef enum logic {
        WB_RESULT = 1'b0,
        WB_PC     = 1'b1
    } wb_sel_e;

    typedef struct packed {
        unit_sel_e             unit;
        alu_op_e               alu_op;
        br_op_e                br_op;
        div_op_e               div_op;
        mem_op_t               mem_op;
        logic                  we;
        wb_sel_e               wb_sel;
        logic [`EXEC_RA_W-1:0] rd;
        logic [`EXEC_PC_W:1]   pc_inc;
        logic [`EXEC_XLEN-1:0] op_a;
        logic [`EXEC_XLEN-1:0] op_b;
        logic [`EXEC_XLEN-1:0] st_data;
        logic [2:0]            lt_ltu_eq;   // {lt, ltu, eq} of rs1 against rs2
    } exec_uop_t;

    typedef struct packed {
        logic                  we;
        wb_sel_e               wb_sel;
        logic [`EXEC_RA_W-1:0] rd;
        logic [`EXEC_PC_W:1]   pc_inc;
        logic [`EXEC_XLEN-1:0] result;
    } exec_wb_t;

endpackage

//--- hdl/mem_pkg.sv
// Data memory port types shared by the load/store unit and the execute top level

`include "exec_defines.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        mem_size_e size;
        logic      store;    // Low for load
        logic      uns;      // Zero-extend on load
    } mem_op_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] addr;
        logic [`EXEC_XLEN-1:0] wdata;   // Already placed in its byte lanes
        logic [3:0]            mask;    // One bit per byte lane
        logic                  write;
    } mem_req_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] rdata;
        logic                  stall;
    } mem_rsp_t;

endpackage

//--- include/exec_defines.svh
// Execute stage widths and divider iteration count as guarded macros

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Operand and result width
`define EXEC_XLEN 32

// Half-word program counter over bits 18:1
`define EXEC_PC_W 18

// Register file address
`define EXEC_RA_W 5

// One quotient bit per iteration
`define EXEC_DIV_STEPS 32

`endif
